/* tb.f */
+incdir+hw
hw/cobs_pkg.sv
hw/byte_fifo.sv
hw/cobs_segmenter.sv
hw/cobs_sequencer.sv
hw/skid_buffer.sv
hw/cobs_encode.sv
test/clk_gen.sv
test/tb_cobs_encode.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cobs_encode
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard hw/*.sv hw/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_cobs_encode.sv */
module tb_cobs_encode;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_FRAMES = 16;
    localparam logic [31:0] SEED = 32'h97f4_b260;

    typedef logic [7:0] byte_q_t[$];

    logic clk;
    logic rst;
    cobs_pkg::beat_t in_beat;
    logic in_valid;
    logic in_ready;
    cobs_pkg::beat_t out_beat;
    logic out_valid;
    logic out_ready;

    // frame table, head bytes first, then generated filler
    string frame_name[NUM_FRAMES];
    int head_len[NUM_FRAMES];
    logic [63:0] head[NUM_FRAMES];
    int fill_len[NUM_FRAMES];
    bit fill_zeros[NUM_FRAMES];
    bit frame_err[NUM_FRAMES];
    bit frame_stall[NUM_FRAMES];
    int table_size;

    // all frames back to back, with per frame offsets
    byte_q_t in_bytes;
    byte_q_t exp_bytes;
    int in_start[NUM_FRAMES];
    int in_len[NUM_FRAMES];
    int exp_start[NUM_FRAMES];
    int exp_len[NUM_FRAMES];

    logic [31:0] fill_rand;
    logic [31:0] drv_rand;
    logic [31:0] mon_rand;
    int error_count;
    int tests_passed;
    int tests_failed;
    int cycle_count;
    int cycle_limit;

    clk_gen clock0 (
        .clk(clk),
        .rst(rst)
    );

    cobs_encode dut0 (
        .clk(clk),
        .rst(rst),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_beat(out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void add_frame(input string name, input int hlen,
                                      input logic [63:0] hbytes, input int fill,
                                      input bit zeros, input bit err, input bit stall);
        frame_name[table_size] = name;
        head_len[table_size] = hlen;
        head[table_size] = hbytes;
        fill_len[table_size] = fill;
        fill_zeros[table_size] = zeros;
        frame_err[table_size] = err;
        frame_stall[table_size] = stall;
        table_size++;
    endfunction

    // COBS without trailing overhead, plus fail code and framing zero
    function automatic void cobs_reference(input byte_q_t raw, input bit err,
                                           output byte_q_t enc);
        byte_q_t run;
        int n;
        int i;
        enc = {};
        run = {};
        // the errored last byte closes its run like a zero
        n = err ? raw.size() - 1 : raw.size();
        for (i = 0; i < n; i++) begin
            if (raw[i] == 8'h00) begin
                enc.push_back(8'(run.size() + 1));
                enc = {enc, run};
                run = {};
            end else begin
                run.push_back(raw[i]);
                if (run.size() == 254) begin
                    enc.push_back(8'hff);
                    enc = {enc, run};
                    run = {};
                end
            end
        end
        if (err || run.size() > 0 || raw[raw.size() - 1] == 8'h00) begin
            enc.push_back(8'(run.size() + 1));
            enc = {enc, run};
        end
        if (err) begin
            enc.push_back(8'h02);
        end
        enc.push_back(8'h00);
    endfunction

    function automatic void build_table();
        byte_q_t frame;
        byte_q_t enc;
        int f;
        int k;
        fill_rand = SEED;
        for (f = 0; f < table_size; f++) begin
            frame = {};
            for (k = 0; k < head_len[f]; k++) begin
                frame.push_back(8'(head[f] >> (8 * (head_len[f] - 1 - k))));
            end
            for (k = 0; k < fill_len[f]; k++) begin
                fill_rand = lcg_step(fill_rand);
                if (fill_zeros[f] && fill_rand[17:16] == 2'b00) begin
                    frame.push_back(8'h00);
                end else begin
                    frame.push_back(8'(fill_rand[31:24] % 8'd255 + 8'd1));
                end
            end
            in_start[f] = in_bytes.size();
            in_len[f] = frame.size();
            in_bytes = {in_bytes, frame};
            cobs_reference(frame, frame_err[f], enc);
            exp_start[f] = exp_bytes.size();
            exp_len[f] = enc.size();
            exp_bytes = {exp_bytes, enc};
        end
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %0h, actual %0h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string test, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("passed %s", test);
        end else begin
            tests_failed++;
            $display("failed %s with %0d mismatches", test, error_count - errs_before);
        end
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = error_count;
        @(posedge clk);
        @(negedge clk);
        while (rst) begin
            check_value("reset_quiet", "out_valid in reset", 32'd0, 32'(out_valid));
            @(negedge clk);
        end
        // last reset edge, then the first free edge
        repeat (2) begin
            check_value("reset_quiet", "out_valid after reset", 32'd0, 32'(out_valid));
            check_value("reset_quiet", "in_ready after reset", 32'd1, 32'(in_ready));
            @(negedge clk);
        end
        report_test("reset_quiet", errs_before);
    endtask

    task automatic drive_frames();
        int f;
        int k;
        bit accepted;
        for (f = 0; f < table_size; f++) begin
            for (k = 0; k < in_len[f]; k++) begin
                if (frame_stall[f]) begin
                    drv_rand = lcg_step(drv_rand);
                    while (drv_rand[17:16] == 2'b00) begin
                        in_valid = 1'b0;
                        @(negedge clk);
                        drv_rand = lcg_step(drv_rand);
                    end
                end
                in_beat.data = in_bytes[in_start[f] + k];
                in_beat.last = (k == in_len[f] - 1);
                in_beat.err = in_beat.last && frame_err[f];
                in_valid = 1'b1;
                // in_ready only moves on rising edges
                do begin
                    accepted = in_ready;
                    @(negedge clk);
                end while (!accepted);
            end
        end
        in_valid = 1'b0;
        in_beat = '0;
    endtask

    task automatic collect_frames();
        cobs_pkg::beat_t got[$];
        cobs_pkg::beat_t exp_beat;
        int f;
        int j;
        int n;
        int errs_before;
        bit done;
        logic rdy;
        for (f = 0; f < table_size; f++) begin
            errs_before = error_count;
            got = {};
            done = 1'b0;
            while (!done) begin
                @(negedge clk);
                if (frame_stall[f]) begin
                    mon_rand = lcg_step(mon_rand);
                    rdy = (mon_rand[17:16] != 2'b00);
                end else begin
                    rdy = 1'b1;
                end
                out_ready = rdy;
                // this beat leaves on the next rising edge
                if (out_valid && rdy) begin
                    got.push_back(out_beat);
                    done = out_beat.last;
                end
            end
            check_value(frame_name[f], "beat count", exp_len[f], got.size());
            n = (got.size() < exp_len[f]) ? got.size() : exp_len[f];
            for (j = 0; j < n; j++) begin
                exp_beat.data = exp_bytes[exp_start[f] + j];
                exp_beat.last = (j == exp_len[f] - 1);
                exp_beat.err = exp_beat.last && frame_err[f];
                check_value(frame_name[f], $sformatf("beat %0d", j), 32'(exp_beat),
                            32'(got[j]));
            end
            report_test(frame_name[f], errs_before);
        end
    endtask

    initial begin
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, output frames still missing", cycle_count);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        in_beat = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;

        add_frame("no_zeros", 3, 64'h11_2233, 0, 0, 0, 0);
        add_frame("single_zero", 1, 64'h00, 0, 0, 0, 0);
        add_frame("leading_zeros", 4, 64'h0000_4142, 0, 0, 0, 0);
        add_frame("middle_zeros", 4, 64'h4100_0042, 0, 0, 0, 0);
        add_frame("trailing_zero", 3, 64'h41_4200, 0, 0, 0, 0);
        add_frame("all_zeros", 3, 64'h00_0000, 0, 0, 0, 0);
        add_frame("run_300", 0, 64'h0, 300, 0, 0, 0);
        add_frame("run_254", 0, 64'h0, 254, 0, 0, 0);
        add_frame("run_508", 0, 64'h0, 508, 0, 0, 0);
        add_frame("error_short", 3, 64'h41_4243, 0, 0, 1, 0);
        add_frame("error_after_zero", 3, 64'h41_0055, 0, 0, 1, 0);
        add_frame("error_single", 1, 64'h77, 0, 0, 1, 0);
        add_frame("mixed_stall_a", 0, 64'h0, 40, 1, 0, 1);
        add_frame("mixed_stall_b", 1, 64'h00, 120, 1, 0, 1);
        add_frame("run_300_stall", 0, 64'h0, 300, 0, 0, 1);
        add_frame("error_stall", 2, 64'h1020, 30, 1, 1, 1);
        build_table();

        drv_rand = fill_rand;
        mon_rand = ~fill_rand;
        cycle_limit = 8 * in_bytes.size() + 200;

        check_reset();
        fork
            drive_frames();
            collect_frames();
        join

        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* test/clk_gen.sv */
module clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // held for two rising edges, released with the second one
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* hw/cobs_encode.sv */
module cobs_encode (
    input  logic            clk,
    input  logic            rst,
    input  cobs_pkg::beat_t in_beat,
    input  logic            in_valid,
    output logic            in_ready,
    output cobs_pkg::beat_t out_beat,
    output logic            out_valid,
    input  logic            out_ready
);

    cobs_pkg::beat_t code_in;
    cobs_pkg::beat_t code_out;
    cobs_pkg::beat_t data_in;
    cobs_pkg::beat_t data_out;
    cobs_pkg::beat_t mid_beat;
    logic code_in_valid;
    logic code_in_ready;
    logic code_out_valid;
    logic code_out_ready;
    logic data_in_valid;
    logic data_in_ready;
    logic data_out_valid;
    logic data_out_ready;
    logic mid_valid;
    logic mid_ready;

    cobs_segmenter segmenter (
        .clk(clk),
        .rst(rst),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .code_in(code_in),
        .code_valid(code_in_valid),
        .code_ready(code_in_ready),
        .data_in(data_in),
        .data_valid(data_in_valid),
        .data_ready(data_in_ready)
    );

    // code bytes, one per run plus the frame terminator
    byte_fifo code_fifo (
        .clk(clk),
        .rst(rst),
        .wr_beat(code_in),
        .wr_valid(code_in_valid),
        .wr_ready(code_in_ready),
        .rd_beat(code_out),
        .rd_valid(code_out_valid),
        .rd_ready(code_out_ready)
    );

    byte_fifo data_fifo (
        .clk(clk),
        .rst(rst),
        .wr_beat(data_in),
        .wr_valid(data_in_valid),
        .wr_ready(data_in_ready),
        .rd_beat(data_out),
        .rd_valid(data_out_valid),
        .rd_ready(data_out_ready)
    );

    cobs_sequencer sequencer (
        .clk(clk),
        .rst(rst),
        .code_beat(code_out),
        .code_valid(code_out_valid),
        .code_ready(code_out_ready),
        .data_beat(data_out),
        .data_valid(data_out_valid),
        .data_ready(data_out_ready),
        .mid_beat(mid_beat),
        .mid_valid(mid_valid),
        .mid_ready(mid_ready)
    );

    skid_buffer output_stage (
        .clk(clk),
        .rst(rst),
        .mid_beat(mid_beat),
        .mid_valid(mid_valid),
        .mid_ready(mid_ready),
        .out_beat(out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

/* hw/skid_buffer.sv */
module skid_buffer (
    input  logic            clk,
    input  logic            rst,
    input  cobs_pkg::beat_t mid_beat,
    input  logic            mid_valid,
    output logic            mid_ready,
    output cobs_pkg::beat_t out_beat,
    output logic            out_valid,
    input  logic            out_ready
);

    cobs_pkg::beat_t out_reg;
    cobs_pkg::beat_t temp_reg;
    logic out_valid_reg;
    logic temp_valid_reg;
    logic ready_reg;
    logic ready_early;

    assign out_beat = out_reg;
    assign out_valid = out_valid_reg;
    assign mid_ready = ready_reg;

    // keep accepting unless the temp register could fill next cycle
    assign ready_early = out_ready || (!temp_valid_reg && (!out_valid_reg || !mid_valid));

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
            temp_valid_reg <= 1'b0;
            ready_reg <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (ready_reg) begin
                if (out_ready || !out_valid_reg) begin
                    out_valid_reg <= mid_valid;
                end else begin
                    temp_valid_reg <= mid_valid;
                end
            end else if (out_ready) begin
                // drain the held beat
                out_valid_reg <= temp_valid_reg;
                temp_valid_reg <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready_reg) begin
            if (out_ready || !out_valid_reg) begin
                out_reg <= mid_beat;
            end else begin
                temp_reg <= mid_beat;
            end
        end else if (out_ready) begin
            out_reg <= temp_reg;
        end
    end

endmodule

/* hw/cobs_sequencer.sv */
`include "cobs_settings.svh"

module cobs_sequencer (
    input  logic            clk,
    input  logic            rst,
    input  cobs_pkg::beat_t code_beat,
    input  logic            code_valid,
    output logic            code_ready,
    input  cobs_pkg::beat_t data_beat,
    input  logic            data_valid,
    output logic            data_ready,
    output cobs_pkg::beat_t mid_beat,
    output logic            mid_valid,
    input  logic            mid_ready
);

    localparam int W = `COBS_BYTE_W;
    localparam logic [W-1:0] CODE_ZERO = W'(`COBS_CODE_ZERO);
    localparam logic [W-1:0] FRAME_END = W'(`COBS_FRAME_END);

    cobs_pkg::seq_state_t state, state_next;
    // run bytes still owed for the current code
    logic [W-1:0] count, count_next;

    always_comb begin
        state_next = state;
        count_next = count;
        mid_beat = '0;
        mid_valid = 1'b0;
        code_ready = 1'b0;
        data_ready = 1'b0;

        case (state)
            cobs_pkg::CODE: begin
                if (mid_ready && code_valid) begin
                    mid_beat.data = code_beat.data;
                    mid_beat.last = code_beat.last;
                    // only the frame terminator reports the error
                    mid_beat.err = code_beat.err && code_beat.last;
                    mid_valid = 1'b1;
                    code_ready = 1'b1;
                    count_next = code_beat.data - W'(1);
                    // empty runs, terminator and fail code have no data behind them
                    if (code_beat.data != FRAME_END && code_beat.data != CODE_ZERO &&
                        !code_beat.err) begin
                        state_next = cobs_pkg::DATA;
                    end
                end
            end
            cobs_pkg::DATA: begin
                if (mid_ready && data_valid) begin
                    mid_beat = data_beat;
                    mid_valid = 1'b1;
                    data_ready = 1'b1;
                    count_next = count - W'(1);
                    if (count == W'(1)) begin
                        state_next = cobs_pkg::CODE;
                    end
                end
            end
            default: begin
                state_next = cobs_pkg::CODE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cobs_pkg::CODE;
            count <= '0;
        end else begin
            state <= state_next;
            count <= count_next;
        end
    end

endmodule

/* hw/cobs_segmenter.sv */
`include "cobs_settings.svh"

module cobs_segmenter (
    input  logic            clk,
    input  logic            rst,
    input  cobs_pkg::beat_t in_beat,
    input  logic            in_valid,
    output logic            in_ready,
    output cobs_pkg::beat_t code_in,
    output logic            code_valid,
    input  logic            code_ready,
    output cobs_pkg::beat_t data_in,
    output logic            data_valid,
    input  logic            data_ready
);

    localparam int W = `COBS_BYTE_W;
    localparam logic [W-1:0] CODE_ZERO = W'(`COBS_CODE_ZERO);
    localparam logic [W-1:0] CODE_FAIL = W'(`COBS_CODE_FAIL);
    localparam logic [W-1:0] CODE_MAX  = W'(`COBS_CODE_MAX);
    localparam logic [W-1:0] FRAME_END = W'(`COBS_FRAME_END);
    localparam logic [W-1:0] MAX_RUN   = W'(`COBS_MAX_RUN);

    cobs_pkg::seg_state_t state, state_next;
    // holds the code value of the open run, so it starts at one
    logic [W-1:0] count, count_next;
    logic fail, fail_next;

    logic tail;
    logic take;
    logic cut;
    logic code_push;
    logic data_push;

    // frame closing states own the code FIFO, input is held off
    assign tail = (state == cobs_pkg::FINAL_ZERO) || (state == cobs_pkg::APPEND_ZERO);
    assign in_ready = !tail && code_ready && data_ready;
    assign take = in_valid && in_ready;

    // a zero byte or an errored last byte ends the current run
    assign cut = (in_beat.data == FRAME_END) || (in_beat.last && in_beat.err);

    // each FIFO sees valid only if the other one can take its part too
    assign code_valid = code_push && (tail || data_ready);
    assign data_valid = data_push && code_ready;

    always_comb begin
        state_next = state;
        count_next = count;
        fail_next = fail;
        code_in = '0;
        code_push = 1'b0;
        data_push = 1'b0;
        data_in.data = in_beat.data;
        // frame end travels on the code stream only
        data_in.last = 1'b0;
        data_in.err = 1'b0;

        case (state)
            cobs_pkg::IDLE, cobs_pkg::SEGMENT: begin
                if (cut) begin
                    code_push = in_valid;
                    code_in.data = count;
                    if (take) begin
                        count_next = CODE_ZERO;
                        if (in_beat.last) begin
                            fail_next = in_beat.err;
                            state_next = cobs_pkg::FINAL_ZERO;
                        end else begin
                            state_next = cobs_pkg::IDLE;
                        end
                    end
                end else begin
                    data_push = in_valid;
                    // run limit or frame end closes the segment with this byte
                    code_push = in_valid && (count == MAX_RUN || in_beat.last);
                    code_in.data = (count == MAX_RUN) ? CODE_MAX : count + W'(1);
                    if (take) begin
                        if (count == MAX_RUN) begin
                            count_next = CODE_ZERO;
                        end else begin
                            count_next = count + W'(1);
                        end
                        if (in_beat.last) begin
                            state_next = cobs_pkg::APPEND_ZERO;
                        end else begin
                            state_next = cobs_pkg::SEGMENT;
                        end
                    end
                end
            end
            cobs_pkg::FINAL_ZERO: begin
                // empty run after a trailing zero, or the fail marker
                code_push = 1'b1;
                code_in.data = fail ? CODE_FAIL : CODE_ZERO;
                code_in.err = fail;
                if (code_ready) begin
                    state_next = cobs_pkg::APPEND_ZERO;
                end
            end
            cobs_pkg::APPEND_ZERO: begin
                code_push = 1'b1;
                code_in.data = FRAME_END;
                code_in.last = 1'b1;
                code_in.err = fail;
                if (code_ready) begin
                    fail_next = 1'b0;
                    count_next = CODE_ZERO;
                    state_next = cobs_pkg::IDLE;
                end
            end
            default: begin
                state_next = cobs_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cobs_pkg::IDLE;
            count <= CODE_ZERO;
            fail <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            fail <= fail_next;
        end
    end

endmodule

/* hw/byte_fifo.sv */
`include "cobs_settings.svh"

module byte_fifo #(
    parameter int depth = `COBS_FIFO_DEPTH
) (
    input  logic            clk,
    input  logic            rst,
    input  cobs_pkg::beat_t wr_beat,
    input  logic            wr_valid,
    output logic            wr_ready,
    output cobs_pkg::beat_t rd_beat,
    output logic            rd_valid,
    input  logic            rd_ready
);

    localparam int AW = $clog2(depth);

    cobs_pkg::beat_t mem [depth];

    // one extra bit to tell full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic full;
    logic empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign wr_ready = !full;
    assign rd_valid = !empty;
    assign rd_beat = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr_valid && wr_ready) begin
            mem[wr_ptr[AW-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_valid && wr_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_valid && rd_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* hw/cobs_pkg.sv */
`include "cobs_settings.svh"

package cobs_pkg;

    // one byte of the stream with its sideband flags
    typedef struct packed {
        logic [`COBS_BYTE_W-1:0] data;
        logic last;
        logic err;
    } beat_t;

    // input side, splits the frame into runs
    typedef enum logic [1:0] {
        IDLE,
        SEGMENT,
        FINAL_ZERO,
        APPEND_ZERO
    } seg_state_t;

    // output side, code byte then its run bytes
    typedef enum logic {
        CODE,
        DATA
    } seq_state_t;

endpackage

/* hw/cobs_settings.svh */
`ifndef COBS_SETTINGS_SVH
`define COBS_SETTINGS_SVH

// stream byte and FIFO sizing
`define COBS_BYTE_W 8
`define COBS_FIFO_DEPTH 256

// a run of this many non-zero bytes closes its segment
`define COBS_MAX_RUN 254

// code values
`define COBS_CODE_ZERO 1
`define COBS_CODE_FAIL 2
`define COBS_CODE_MAX 255
`define COBS_FRAME_END 0

`endif
